// ==== logic/fm_geom_pkg.sv ====
// ##################################################
// Feature map geometry types
// ##################################################

package fm_geom_pkg;

    // Default map and tile sizes shared by the top level and the testbench
    parameter int M_DEF  = 4;
    parameter int R_DEF  = 8;
    parameter int C_DEF  = 16;
    parameter int TM_DEF = 2;
    parameter int TR_DEF = 4;
    parameter int TC_DEF = 6;

    // Counts and coordinates
    typedef logic [15:0] cw_t;

    // First channel, row and column of a tile
    typedef struct packed {
        cw_t tile_base_n;
        cw_t tile_base_row;
        cw_t tile_base_col;
    } tile_org_t;

    // One tile row as handed from the controller to the reader
    typedef struct packed {
        logic [31:0] raddr;   // byte address of the first aligned beat
        cw_t         nbeat;
    } row_trans_t;

endpackage

// ==== logic/out_fm_ld_filter.sv ====
// ##################################################
// Tile column filter
// ##################################################

`timescale 1ns/100ps

module out_fm_ld_filter #(
    parameter int TC = 6
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        word_valid,
    input  logic [31:0] word,
    input  logic [1:0]  lead,
    input  logic        row_start,
    output logic        load_fifo_push,
    output logic [31:0] load_data,
    output logic        busy
);

    fm_geom_pkg::cw_t idx;
    fm_geom_pkg::cw_t lo;
    fm_geom_pkg::cw_t hi;
    logic             keep;

    // Window of kept words within the aligned row span
    assign lo   = fm_geom_pkg::cw_t'(lead);
    assign hi   = lo + fm_geom_pkg::cw_t'(TC);
    assign keep = word_valid && (idx >= lo) && (idx < hi);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            idx            <= '0;
            load_fifo_push <= 1'b0;
        end else begin
            if (row_start) begin
                idx <= '0;
            end else if (word_valid) begin
                idx <= idx + 1'b1;
            end
            load_fifo_push <= keep;
        end
    end

    always_ff @(posedge clk) begin
        if (keep) begin
            load_data <= word;
        end
    end

    // Words still between the reader and the FIFO
    assign busy = word_valid | load_fifo_push;

endmodule

// ==== logic/out_fm_loader_top.sv ====
// ##################################################
// Output feature map tile loader
// ##################################################

`timescale 1ns/100ps

module out_fm_loader_top #(
    parameter int M      = fm_geom_pkg::M_DEF,
    parameter int R      = fm_geom_pkg::R_DEF,
    parameter int C      = fm_geom_pkg::C_DEF,
    parameter int TM     = fm_geom_pkg::TM_DEF,
    parameter int TR     = fm_geom_pkg::TR_DEF,
    parameter int TC     = fm_geom_pkg::TC_DEF,
    parameter int BLEN_P = rmst_bus_pkg::BLEN,
    parameter int CAP_P  = rmst_bus_pkg::RD_CAP
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     load_req,
    input  fm_geom_pkg::tile_org_t   tile_org,
    output logic                     load_ack,
    input  logic                     load_almost_full,
    output logic                     rmst_go,
    output rmst_bus_pkg::burst_cmd_t rmst_cmd,
    input  logic                     rmst_done,
    output logic                     rmst_read_buffer,
    input  rmst_bus_pkg::beat_t      rmst_beat,
    input  logic                     rmst_data_available,
    output logic                     load_fifo_push,
    output logic [31:0]              load_data
);

    logic                    trans_req;
    logic                    trans_ack;
    fm_geom_pkg::row_trans_t trans;
    logic [1:0]              lead;
    logic                    row_start;
    logic                    busy;
    logic                    word_valid;
    logic [31:0]             word;

    out_fm_tile_ctrl #(
        .M  (M),
        .R  (R),
        .C  (C),
        .TM (TM),
        .TR (TR),
        .TC (TC)
    ) u_ctrl (
        .clk              (clk),
        .rst              (rst),
        .load_req         (load_req),
        .tile_org         (tile_org),
        .load_ack         (load_ack),
        .load_almost_full (load_almost_full),
        .trans_req        (trans_req),
        .trans            (trans),
        .trans_ack        (trans_ack),
        .lead             (lead),
        .row_start        (row_start),
        .busy             (busy)
    );

    rmst_burst_reader #(
        .BLEN_P (BLEN_P),
        .CAP_P  (CAP_P)
    ) u_reader (
        .clk                 (clk),
        .rst                 (rst),
        .trans_req           (trans_req),
        .trans               (trans),
        .trans_ack           (trans_ack),
        .rmst_go             (rmst_go),
        .rmst_cmd            (rmst_cmd),
        .rmst_done           (rmst_done),
        .rmst_read_buffer    (rmst_read_buffer),
        .rmst_beat           (rmst_beat),
        .rmst_data_available (rmst_data_available),
        .word_valid          (word_valid),
        .word                (word)
    );

    out_fm_ld_filter #(
        .TC (TC)
    ) u_filter (
        .clk            (clk),
        .rst            (rst),
        .word_valid     (word_valid),
        .word           (word),
        .lead           (lead),
        .row_start      (row_start),
        .load_fifo_push (load_fifo_push),
        .load_data      (load_data),
        .busy           (busy)
    );

endmodule

// ==== logic/out_fm_tile_ctrl.sv ====
// ##################################################
// Output feature map tile sequencer
// ##################################################

`timescale 1ns/100ps

module out_fm_tile_ctrl #(
    parameter int M  = 4,
    parameter int R  = 8,
    parameter int C  = 16,
    parameter int TM = 2,
    parameter int TR = 4,
    parameter int TC = 6
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    load_req,
    input  fm_geom_pkg::tile_org_t  tile_org,
    output logic                    load_ack,
    input  logic                    load_almost_full,
    output logic                    trans_req,
    output fm_geom_pkg::row_trans_t trans,
    input  logic                    trans_ack,
    output logic [1:0]              lead,
    output logic                    row_start,
    input  logic                    busy
);

    // Element index sized to the whole map
    localparam int FM_WORDS = M * R * C;
    localparam int EW       = $clog2(FM_WORDS);
    localparam int LW       = $clog2(rmst_bus_pkg::WCNT);

    typedef enum logic [1:0] {IDLE, ISSUE, WAIT, DONE} ctrl_state_t;

    ctrl_state_t             state;
    fm_geom_pkg::tile_org_t  org;
    fm_geom_pkg::cw_t        ch_i;
    fm_geom_pkg::cw_t        row_i;
    logic [EW-1:0]           elem;
    logic [1:0]              lead_nx;
    fm_geom_pkg::cw_t        nbeat_nx;
    logic [31:0]             raddr_nx;
    logic                    last_row;
    logic                    issue;

    // Address of the current row's first element, channel-major layout
    always_comb begin
        elem = EW'((32'(org.tile_base_n + ch_i) * R + 32'(org.tile_base_row + row_i)) * C
                   + 32'(org.tile_base_col));
        lead_nx  = elem[1:0];
        raddr_nx = 32'({elem[EW-1:LW], {LW{1'b0}}}) << 2;
        nbeat_nx = (fm_geom_pkg::cw_t'(lead_nx)
                    + fm_geom_pkg::cw_t'(TC + rmst_bus_pkg::WCNT - 1)) >> LW;
    end

    assign last_row = (ch_i == fm_geom_pkg::cw_t'(TM - 1))
                   && (row_i == fm_geom_pkg::cw_t'(TR - 1));

    // Row back-pressure: hold off while the load FIFO is nearly full
    assign issue = (state == ISSUE) && !trans_ack && !load_almost_full;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= IDLE;
            load_ack  <= 1'b0;
            trans_req <= 1'b0;
            row_start <= 1'b0;
            ch_i      <= '0;
            row_i     <= '0;
        end else begin
            row_start <= 1'b0;
            case (state)
                IDLE: begin
                    if (load_req) begin
                        ch_i  <= '0;
                        row_i <= '0;
                        state <= ISSUE;
                    end
                end
                ISSUE: begin
                    if (issue) begin
                        trans_req <= 1'b1;
                        row_start <= 1'b1;
                        state     <= WAIT;
                    end
                end
                WAIT: begin
                    if (trans_ack) begin
                        trans_req <= 1'b0;
                        if (row_i == fm_geom_pkg::cw_t'(TR - 1)) begin
                            row_i <= '0;
                            ch_i  <= ch_i + 1'b1;
                        end else begin
                            row_i <= row_i + 1'b1;
                        end
                        state <= last_row ? DONE : ISSUE;
                    end
                end
                DONE: begin
                    // Ack only once the reader has closed its handshake and the filter is empty
                    if (!load_ack) begin
                        if (!trans_ack && !busy) begin
                            load_ack <= 1'b1;
                        end
                    end else if (!load_req) begin
                        load_ack <= 1'b0;
                        state    <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && load_req) begin
            org <= tile_org;
        end
        if (issue) begin
            trans.raddr <= raddr_nx;
            trans.nbeat <= nbeat_nx;
            lead        <= lead_nx;
        end
    end

endmodule

// ==== logic/rmst_burst_reader.sv ====
// ##################################################
// Burst reader and beat unpacker
// ##################################################

`timescale 1ns/100ps

module rmst_burst_reader #(
    parameter int BLEN_P = 8,
    parameter int CAP_P  = 16
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       trans_req,
    input  fm_geom_pkg::row_trans_t    trans,
    output logic                       trans_ack,
    output logic                       rmst_go,
    output rmst_bus_pkg::burst_cmd_t   rmst_cmd,
    input  logic                       rmst_done,
    output logic                       rmst_read_buffer,
    input  rmst_bus_pkg::beat_t        rmst_beat,
    input  logic                       rmst_data_available,
    output logic                       word_valid,
    output logic [31:0]                word
);

    localparam int WCNT       = rmst_bus_pkg::WCNT;
    localparam int DW         = rmst_bus_pkg::DW;
    localparam int BEAT_BYTES = rmst_bus_pkg::XDW / 8;

    logic                          active;
    logic                          burst_out;
    logic                          start;
    logic                          pop;
    logic                          last_word;
    logic [rmst_bus_pkg::XAW-1:0]  base;
    fm_geom_pkg::cw_t              issue_left;
    fm_geom_pkg::cw_t              pop_left;
    fm_geom_pkg::cw_t              inflight;
    fm_geom_pkg::cw_t              blen_now;
    logic [15:0]                   len_bytes;
    logic [WCNT-1:0]               word_en;
    rmst_bus_pkg::beat_t           sh;

    // New row when the request is up and the previous handshake has closed
    assign start = trans_req && !active && !trans_ack;

    always_comb begin
        if (issue_left > fm_geom_pkg::cw_t'(BLEN_P)) begin
            blen_now = fm_geom_pkg::cw_t'(BLEN_P);
        end else begin
            blen_now = issue_left;
        end
        len_bytes = 16'(blen_now * BEAT_BYTES);
    end

    // One burst at a time, and never more than CAP_P beats unpopped
    assign rmst_go = active && !burst_out && (issue_left != '0)
                  && ((inflight + blen_now) <= fm_geom_pkg::cw_t'(CAP_P));

    always_comb begin
        rmst_cmd.base   = base;
        rmst_cmd.length = len_bytes;
    end

    // Pop on an empty unpacker or while its last word leaves
    assign pop = rmst_data_available && (pop_left != '0)
              && ((word_en == '0) || word_en[WCNT-1]);
    assign rmst_read_buffer = pop;

    assign last_word = word_en[WCNT-1] && (pop_left == '0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            active     <= 1'b0;
            trans_ack  <= 1'b0;
            issue_left <= '0;
            pop_left   <= '0;
        end else begin
            if (start) begin
                active     <= 1'b1;
                issue_left <= trans.nbeat;
                pop_left   <= trans.nbeat;
            end else begin
                if (rmst_go) begin
                    issue_left <= issue_left - blen_now;
                end
                if (pop) begin
                    pop_left <= pop_left - 1'b1;
                end
                if (active && last_word) begin
                    active    <= 1'b0;
                    trans_ack <= 1'b1;
                end
            end
            if (trans_ack && !trans_req) begin
                trans_ack <= 1'b0;
            end
        end
    end

    // Burst bookkeeping survives row boundaries
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            burst_out <= 1'b0;
            inflight  <= '0;
        end else begin
            if (rmst_go) begin
                burst_out <= 1'b1;
            end else if (rmst_done) begin
                burst_out <= 1'b0;
            end
            inflight <= inflight + (rmst_go ? blen_now : '0) - (pop ? 16'd1 : 16'd0);
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            base <= trans.raddr;
        end else if (rmst_go) begin
            base <= base + rmst_bus_pkg::XAW'(len_bytes);
        end
    end

    // One-hot enable walks the four words of each popped beat
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            word_en <= '0;
        end else if (pop) begin
            word_en <= WCNT'(1);
        end else begin
            word_en <= word_en << 1;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            sh <= rmst_beat;
        end else begin
            sh <= sh >> DW;
        end
    end

    assign word_valid = |word_en;
    assign word       = sh[0];

endmodule

// ==== logic/rmst_bus_pkg.sv ====
// ##################################################
// Read master bus types
// ##################################################

package rmst_bus_pkg;

    parameter int XAW  = 32;
    parameter int XDW  = 128;
    parameter int DW   = 32;
    parameter int WCNT = XDW / DW;

    // Largest burst in beats
    parameter int BLEN = 8;

    // Beats the reader may have requested but not yet popped
    parameter int RD_CAP = 16;

    // Burst request, length in bytes
    typedef struct packed {
        logic [XAW-1:0] base;
        logic [15:0]    length;
    } burst_cmd_t;

    // Word 0 sits in the low bits
    typedef logic [WCNT-1:0][DW-1:0] beat_t;

endpackage

// ==== out_fm_loader_top.f ====
logic/fm_geom_pkg.sv
logic/rmst_bus_pkg.sv
logic/out_fm_tile_ctrl.sv
logic/rmst_burst_reader.sv
logic/out_fm_ld_filter.sv
logic/out_fm_loader_top.sv
tb/out_fm_loader_checker.sv
tb/out_fm_loader_tb.sv

// ==== run.sh ====
#!/bin/sh
# Compile with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert \
    -f out_fm_loader_top.f \
    --top-module out_fm_loader_tb \
    -o out_fm_loader_sim &&
./obj_dir/out_fm_loader_sim +verilator+error+limit+1000 | tee /dev/stderr |
    grep -q "^Regression passed$" &&
echo "Simulation run: PASS" ||
{ echo "Simulation run: FAIL"; exit 1; }

// ==== tb/out_fm_loader_checker.sv ====
// ##################################################
// Tile loader protocol checks
// ##################################################

`timescale 1ns/100ps

module out_fm_loader_checker (
    input logic clk,
    input logic rst,
    input logic load_req,
    input logic load_ack,
    input logic load_fifo_push,
    input logic rmst_go,
    input logic rmst_done,
    input logic rmst_read_buffer,
    input logic rmst_data_available
);

    int   fail_cnt = 0;
    logic burst_open;

    // A burst stays open from rmst_go until its rmst_done
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            burst_open <= 1'b0;
        end else if (rmst_go) begin
            burst_open <= 1'b1;
        end else if (rmst_done) begin
            burst_open <= 1'b0;
        end
    end

    a_pop_avail: assert property (@(posedge clk) disable iff (rst)
        rmst_read_buffer |-> rmst_data_available)
        else begin
            fail_cnt++;
            $error("rmst_read_buffer while no beat is available");
        end

    a_ack_fall: assert property (@(posedge clk) disable iff (rst)
        $fell(load_ack) |-> !$past(load_req))
        else begin
            fail_cnt++;
            $error("load_ack fell while load_req was still high");
        end

    a_one_burst: assert property (@(posedge clk) disable iff (rst)
        rmst_go |-> !burst_open)
        else begin
            fail_cnt++;
            $error("rmst_go before the previous rmst_done");
        end

    // Pushes belong inside an open load handshake
    a_push_idle: assert property (@(posedge clk) disable iff (rst)
        load_fifo_push |-> (load_req && !load_ack))
        else begin
            fail_cnt++;
            $error("load_fifo_push outside a tile load");
        end

endmodule

// ==== tb/out_fm_loader_tb.sv ====
// ##################################################
// Tile loader testbench
// ##################################################

`timescale 1ns/100ps

module out_fm_loader_tb;

    localparam int M          = fm_geom_pkg::M_DEF;
    localparam int R          = fm_geom_pkg::R_DEF;
    localparam int C          = fm_geom_pkg::C_DEF;
    localparam int TM         = fm_geom_pkg::TM_DEF;
    localparam int TR         = fm_geom_pkg::TR_DEF;
    localparam int TC         = fm_geom_pkg::TC_DEF;
    localparam int WCNT       = rmst_bus_pkg::WCNT;
    localparam int BEAT_BYTES = rmst_bus_pkg::XDW / 8;
    localparam int MAX_BYTES  = rmst_bus_pkg::BLEN * BEAT_BYTES;
    localparam int NBEATS     = M * R * C / WCNT;
    localparam int N_RAND     = 30;
    localparam int HOLD       = 40;
    // Two directed tiles and the random ones, 200 cycles each at most
    localparam int CYC_LIMIT  = (N_RAND + 2) * 200 + 2 * HOLD;

    logic                     clk;
    logic                     rst;
    logic                     load_req;
    fm_geom_pkg::tile_org_t   tile_org;
    logic                     load_ack;
    logic                     load_almost_full;
    logic                     rmst_go;
    rmst_bus_pkg::burst_cmd_t rmst_cmd;
    logic                     rmst_done = 1'b0;
    logic                     rmst_read_buffer;
    rmst_bus_pkg::beat_t      rmst_beat = '0;
    logic                     rmst_data_available = 1'b0;
    logic                     load_fifo_push;
    logic [31:0]              load_data;

    rmst_bus_pkg::beat_t    mem [NBEATS];
    int                     beat_q [$];
    logic [31:0]            exp_q [$];
    int                     seed = 52745;
    int                     gap_seed = 52745;
    int                     gap_rnd;
    bit                     gap_on;
    bit                     avail_ok;
    bit                     go_seen;
    int                     data_err;
    int                     hs_err;
    int                     push_cnt;
    int                     cyc;
    int                     bi;
    int                     i;
    int                     w;
    int                     t;
    fm_geom_pkg::tile_org_t org;

    out_fm_loader_top #(
        .M (M), .R (R), .C (C), .TM (TM), .TR (TR), .TC (TC),
        .BLEN_P (rmst_bus_pkg::BLEN),
        .CAP_P  (rmst_bus_pkg::RD_CAP)
    ) DUT (
        .clk                 (clk),
        .rst                 (rst),
        .load_req            (load_req),
        .tile_org            (tile_org),
        .load_ack            (load_ack),
        .load_almost_full    (load_almost_full),
        .rmst_go             (rmst_go),
        .rmst_cmd            (rmst_cmd),
        .rmst_done           (rmst_done),
        .rmst_read_buffer    (rmst_read_buffer),
        .rmst_beat           (rmst_beat),
        .rmst_data_available (rmst_data_available),
        .load_fifo_push      (load_fifo_push),
        .load_data           (load_data)
    );

    bind out_fm_loader_top out_fm_loader_checker u_chk (
        .clk                 (clk),
        .rst                 (rst),
        .load_req            (load_req),
        .load_ack            (load_ack),
        .load_fifo_push      (load_fifo_push),
        .rmst_go             (rmst_go),
        .rmst_done           (rmst_done),
        .rmst_read_buffer    (rmst_read_buffer),
        .rmst_data_available (rmst_data_available)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Read master model and push scoreboard, sampled at the rising edge
    always @(posedge clk) begin
        if (rmst_read_buffer) begin
            if (beat_q.size() == 0) begin
                data_err++;
                $display("Error at %0t: beat popped with none queued", $time);
            end else begin
                void'(beat_q.pop_front());
            end
        end
        if (rmst_go) begin
            // Bursts are whole aligned beats, at most BLEN of them
            if (rmst_cmd.length == 16'd0 || int'(rmst_cmd.length) % BEAT_BYTES != 0
                || int'(rmst_cmd.length) > MAX_BYTES || rmst_cmd.base % BEAT_BYTES != 0) begin
                data_err++;
                $display("Error at %0t: bad burst base %h length %0d",
                         $time, rmst_cmd.base, rmst_cmd.length);
            end
            for (bi = 0; bi < int'(rmst_cmd.length) / BEAT_BYTES; bi++) begin
                beat_q.push_back(int'(rmst_cmd.base / BEAT_BYTES) + bi);
            end
        end
        go_seen = rmst_go;
        gap_rnd = $random(gap_seed);
        avail_ok = !gap_on || gap_rnd[0];
        if (load_fifo_push) begin
            if (push_cnt >= exp_q.size()) begin
                data_err++;
                $display("Error at %0t: push of %h with no word expected", $time, load_data);
            end else if (load_data !== exp_q[push_cnt]) begin
                data_err++;
                $display("Error at %0t: word %0d pushed %h, expected %h",
                         $time, push_cnt, load_data, exp_q[push_cnt]);
            end
            push_cnt++;
        end
    end

    // Done follows the burst by one cycle; beats show up with random gaps
    always @(negedge clk) begin
        rmst_done = go_seen;
        if (beat_q.size() != 0 && avail_ok) begin
            rmst_data_available = 1'b1;
            rmst_beat = mem[beat_q[0]];
        end else begin
            rmst_data_available = 1'b0;
        end
    end

    always @(posedge clk) begin
        cyc++;
        if (cyc >= CYC_LIMIT) begin
            $display("Timeout: tiles not finished within %0d cycles", CYC_LIMIT);
            $display("Regression failed");
            $finish;
        end
    end

    // Expected words of a tile in channel, row, column order
    task automatic queue_tile(input fm_geom_pkg::tile_org_t o);
        int n;
        int r;
        int c;
        int e;
        for (n = 0; n < TM; n++) begin
            for (r = 0; r < TR; r++) begin
                for (c = 0; c < TC; c++) begin
                    e = ((int'(o.tile_base_n) + n) * R + int'(o.tile_base_row) + r) * C
                        + int'(o.tile_base_col) + c;
                    exp_q.push_back(mem[e / WCNT][e % WCNT]);
                end
            end
        end
    endtask

    task automatic run_tile(input fm_geom_pkg::tile_org_t o, input bit hold);
        int p0;
        queue_tile(o);
        tile_org = o;
        load_req = 1'b1;
        if (hold) begin
            // Flag already high when the tile starts, so no row may begin
            load_almost_full = 1'b1;
            p0 = push_cnt;
            repeat (HOLD) @(negedge clk);
            if (push_cnt != p0) begin
                hs_err++;
                $display("Error at %0t: %0d words pushed before the flag dropped",
                         $time, push_cnt - p0);
            end
            load_almost_full = 1'b0;
            while (push_cnt == p0) @(negedge clk);
            load_almost_full = 1'b1;
            p0 = push_cnt;
            repeat (HOLD) @(negedge clk);
            if (push_cnt - p0 > TC) begin
                hs_err++;
                $display("Error at %0t: %0d words pushed with the flag high",
                         $time, push_cnt - p0);
            end
            load_almost_full = 1'b0;
        end
        while (!load_ack) @(negedge clk);
        if (push_cnt != exp_q.size()) begin
            hs_err++;
            $display("Error at %0t: load_ack after %0d of %0d words",
                     $time, push_cnt, exp_q.size());
        end
        load_req = 1'b0;
        while (load_ack) @(negedge clk);
    endtask

    initial begin
        rst = 1'b1;
        load_req = 1'b0;
        tile_org = '0;
        load_almost_full = 1'b0;
        gap_on = 1'b0;
        data_err = 0;
        hs_err = 0;
        push_cnt = 0;
        cyc = 0;
        for (i = 0; i < NBEATS; i++) begin
            for (w = 0; w < WCNT; w++) begin
                mem[i][w] = $random(seed);
            end
        end
        repeat (2) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        // Beat aligned tile with a steady beat supply
        org.tile_base_n = 16'd1;
        org.tile_base_row = 16'd2;
        org.tile_base_col = 16'd4;
        run_tile(org, 1'b0);

        gap_on = 1'b1;
        org.tile_base_n = 16'd0;
        org.tile_base_row = 16'd4;
        org.tile_base_col = 16'd9;
        run_tile(org, 1'b1);

        for (t = 0; t < N_RAND; t++) begin
            org.tile_base_n = fm_geom_pkg::cw_t'($unsigned($random(seed)) % (M - TM + 1));
            org.tile_base_row = fm_geom_pkg::cw_t'($unsigned($random(seed)) % (R - TR + 1));
            org.tile_base_col = fm_geom_pkg::cw_t'($unsigned($random(seed)) % (C - TC + 1));
            run_tile(org, 1'b0);
        end

        if (beat_q.size() != 0) begin
            hs_err++;
            $display("Beats left unread in the read master model: %0d", beat_q.size());
        end
        $display("Done: %0d words, %0d data errors, %0d handshake errors, %0d assertion errors",
                 push_cnt, data_err, hs_err, DUT.u_chk.fail_cnt);
        if (data_err == 0 && hs_err == 0 && DUT.u_chk.fail_cnt == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule
